//--- source/wfe_defines.svh
// widths and window constants for the waveform feature pipeline, include in every design file
`ifndef WFE_DEFINES_SVH
`define WFE_DEFINES_SVH

// sample and accumulation widths
`define WFE_SAMPLE_W      11  // signed input sample
`define WFE_WINDOW_LOG2   6   // window length is 2**this
`define WFE_ACC_W         32  // per-window accumulators

// output formats
`define WFE_FEAT_W        16  // every feature output
`define WFE_FRAC_W        8   // q8.8 fraction bits of the ratios

// reciprocal table
`define WFE_RECIP_IDX_W   4   // table index bits below the leading one
`define WFE_RECIP_W       20  // one table entry, 2**20/(16+i)

`endif

//--- source/wfe_pkg.sv
// shared types of the waveform feature pipeline, referenced by scoped names
`include "wfe_defines.svh"

package wfe_pkg;

    // data types
    typedef logic signed [`WFE_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`WFE_ACC_W-1:0]    acc_t;
    typedef logic [`WFE_FEAT_W-1:0]          feature_t;
    typedef logic [`WFE_RECIP_W-1:0]         recip_t;

    // window collection fsm
    typedef enum logic {
        COLLECT_IDLE,  // waiting for the first sample of a window
        COLLECT_RUN    // inside a window
    } collect_state_e;

    // picks the result a divider gives for a zero divisor
    typedef enum logic {
        RATIO_CREST,   // zero mean square -> full scale
        RATIO_FORM     // zero mean abs -> 1.0
    } ratio_kind_e;

endpackage

//--- source/window_stats_if.sv
// carries one window's raw totals from the accumulator to the formatter
`timescale 1ns/1ps
`include "wfe_defines.svh"

interface window_stats_if;

    logic                      stats_valid;  // one cycle after the last sample
    wfe_pkg::acc_t             sum_signal;
    wfe_pkg::acc_t             sum_abs;
    wfe_pkg::acc_t             sum_square;
    wfe_pkg::sample_t          peak_max;
    wfe_pkg::sample_t          peak_min;
    logic [`WFE_WINDOW_LOG2:0] cross_count;  // sign changes inside the window

    modport driver (
        output stats_valid, sum_signal, sum_abs, sum_square,
        output peak_max, peak_min, cross_count
    );

    // captured in the stats_valid cycle, no stall
    modport receiver (
        input stats_valid, sum_signal, sum_abs, sum_square,
        input peak_max, peak_min, cross_count
    );

endinterface

//--- source/window_accumulator.sv
// collects samples into fixed windows and presents the per-window totals for one cycle
`timescale 1ns/1ps
`include "wfe_defines.svh"

module window_accumulator (
    input  logic                  clk,
    input  logic                  rst_n,
    input  wfe_pkg::sample_t      signal_in,
    input  logic                  signal_valid,
    window_stats_if.driver        stats
);

    localparam int MSB = `WFE_SAMPLE_W - 1;

    wfe_pkg::collect_state_e     state;
    logic [`WFE_WINDOW_LOG2-1:0] sample_cnt;
    wfe_pkg::sample_t            prev_sample;
    wfe_pkg::acc_t               abs_sample;
    wfe_pkg::acc_t               sq_sample;
    logic                        sign_flip;
    logic                        last_sample;

    // ======================================================================
    // per-sample terms
    // ======================================================================
    assign abs_sample  = signal_in[MSB] ? -wfe_pkg::acc_t'(signal_in)
                                        : wfe_pkg::acc_t'(signal_in);
    assign sq_sample   = signal_in * signal_in;  // signed, fits easily in 32 bits
    assign sign_flip   = prev_sample[MSB] ^ signal_in[MSB];
    assign last_sample = signal_valid && (state == wfe_pkg::COLLECT_RUN) && (sample_cnt == '1);

    // ======================================================================
    // collection fsm
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= wfe_pkg::COLLECT_IDLE;
            sample_cnt        <= '0;
            stats.stats_valid <= 1'b0;
        end else begin
            stats.stats_valid <= last_sample;
            if (signal_valid) begin
                sample_cnt <= sample_cnt + 1'b1;  // wraps to 0 on the last sample
                case (state)
                    wfe_pkg::COLLECT_IDLE: state <= wfe_pkg::COLLECT_RUN;
                    wfe_pkg::COLLECT_RUN: begin
                        if (sample_cnt == '1)
                            state <= wfe_pkg::COLLECT_IDLE;
                    end
                    default: state <= wfe_pkg::COLLECT_IDLE;
                endcase
            end
        end
    end

    // ======================================================================
    // accumulators
    // ======================================================================
    // the first sample of a window overwrites, so totals stay put while
    // stats_valid is high and the next window starts clean
    always_ff @(posedge clk) begin
        if (signal_valid) begin
            prev_sample <= signal_in;
            if (state == wfe_pkg::COLLECT_IDLE) begin
                stats.sum_signal  <= wfe_pkg::acc_t'(signal_in);
                stats.sum_abs     <= abs_sample;
                stats.sum_square  <= sq_sample;
                stats.peak_max    <= signal_in;
                stats.peak_min    <= signal_in;
                stats.cross_count <= '0;  // first sample has no predecessor
            end else begin
                stats.sum_signal  <= stats.sum_signal + wfe_pkg::acc_t'(signal_in);
                stats.sum_abs     <= stats.sum_abs + abs_sample;
                stats.sum_square  <= stats.sum_square + sq_sample;
                stats.cross_count <= stats.cross_count + sign_flip;
                if (signal_in > stats.peak_max)
                    stats.peak_max <= signal_in;
                if (signal_in < stats.peak_min)
                    stats.peak_min <= signal_in;
            end
        end
    end

    a_state_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(state));

    // windows are at least two samples long
    a_stats_single: assert property (@(posedge clk) disable iff (!rst_n)
        stats.stats_valid |=> !stats.stats_valid);

endmodule

//--- source/reciprocal_lookup.sv
// normalizes a divisor and registers two neighbouring reciprocal table entries for interpolation
`timescale 1ns/1ps
`include "wfe_defines.svh"

module reciprocal_lookup (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              lookup_valid,
    input  wfe_pkg::feature_t divisor,
    output wfe_pkg::recip_t   recip_base,
    output wfe_pkg::recip_t   recip_next,
    output logic [7:0]        offset,
    output logic [3:0]        norm_shift,
    output logic              zero_divisor,
    output logic              looked_valid
);

    localparam int FW = `WFE_FEAT_W;

    // entry i = round(2**20 / (16 + i)), entry 16 closes the last interval
    localparam wfe_pkg::recip_t RECIP_TABLE [17] = '{
        20'd65536, 20'd61681, 20'd58254, 20'd55188,
        20'd52429, 20'd49932, 20'd47663, 20'd45590,
        20'd43691, 20'd41943, 20'd40330, 20'd38836,
        20'd37449, 20'd36158, 20'd34953, 20'd33825,
        20'd32768
    };

    logic [3:0]                   lead_shift;
    wfe_pkg::feature_t            norm;
    logic [`WFE_RECIP_IDX_W-1:0]  idx;

    // shift that brings the leading one to the msb
    always_comb begin
        lead_shift = '0;
        for (int b = 0; b < FW; b++) begin
            if (divisor[b])
                lead_shift = 4'(FW - 1 - b);
        end
    end

    assign norm = divisor << lead_shift;
    assign idx  = norm[FW-2 -: `WFE_RECIP_IDX_W];  // four bits under the leading one

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            looked_valid <= 1'b0;
        else
            looked_valid <= lookup_valid;
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            recip_base   <= RECIP_TABLE[idx];
            recip_next   <= RECIP_TABLE[{1'b0, idx} + 5'd1];
            offset       <= norm[FW-2-`WFE_RECIP_IDX_W -: 8];
            norm_shift   <= lead_shift;
            zero_divisor <= (divisor == '0);
        end
    end

endmodule

//--- source/ratio_divider.sv
// three-stage q8.8 divider: table lookup, linear interpolation, then multiply and saturate
`timescale 1ns/1ps
`include "wfe_defines.svh"

module ratio_divider #(
    parameter wfe_pkg::ratio_kind_e RATIO_KIND = wfe_pkg::RATIO_CREST
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                job_valid,
    input  logic [`WFE_FEAT_W+`WFE_FRAC_W-1:0]  dividend,
    input  wfe_pkg::feature_t                   divisor,
    output wfe_pkg::feature_t                   quotient,
    output logic                                quotient_valid
);

    localparam int DIV_W  = `WFE_FEAT_W + `WFE_FRAC_W;
    localparam int PROD_W = DIV_W + `WFE_RECIP_W;
    localparam wfe_pkg::feature_t ZERO_RESULT = (RATIO_KIND == wfe_pkg::RATIO_CREST) ?
        {`WFE_FEAT_W{1'b1}} : wfe_pkg::feature_t'(1 << `WFE_FRAC_W);

    wfe_pkg::recip_t          recip_base;
    wfe_pkg::recip_t          recip_next;
    logic [7:0]               offset;
    logic [3:0]               norm_shift;
    logic                     zero_divisor;
    logic                     looked_valid;
    logic [DIV_W-1:0]         dividend_q1;
    logic [DIV_W-1:0]         dividend_q2;
    logic [3:0]               shift_q2;
    logic                     zero_q2;
    logic                     interp_valid;
    wfe_pkg::recip_t          recip_interp;
    wfe_pkg::recip_t          recip_step;
    logic [`WFE_RECIP_W+7:0]  step_scaled;
    logic [PROD_W-1:0]        product;
    logic [PROD_W-1:0]        scaled;

    reciprocal_lookup u_lookup (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_valid (job_valid),
        .divisor      (divisor),
        .recip_base   (recip_base),
        .recip_next   (recip_next),
        .offset       (offset),
        .norm_shift   (norm_shift),
        .zero_divisor (zero_divisor),
        .looked_valid (looked_valid)
    );

    // table falls with i, so interpolate downward from the base entry
    assign recip_step  = recip_base - recip_next;
    assign step_scaled = recip_step * offset;

    // recip is 2**31/norm and norm is divisor << shift
    assign product = dividend_q2 * recip_interp;
    assign scaled  = product >> (5'd31 - {1'b0, shift_q2});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            interp_valid   <= 1'b0;
            quotient_valid <= 1'b0;
        end else begin
            interp_valid   <= looked_valid;
            quotient_valid <= interp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (job_valid)
            dividend_q1 <= dividend;  // rides alongside the lookup
        if (looked_valid) begin
            recip_interp <= recip_base - wfe_pkg::recip_t'(step_scaled >> 8);
            dividend_q2  <= dividend_q1;
            shift_q2     <= norm_shift;
            zero_q2      <= zero_divisor;
        end
        if (interp_valid) begin
            if (zero_q2)
                quotient <= ZERO_RESULT;
            else if (|scaled[PROD_W-1:`WFE_FEAT_W])
                quotient <= {`WFE_FEAT_W{1'b1}};  // saturate
            else
                quotient <= scaled[`WFE_FEAT_W-1:0];
        end
    end

    a_job_latency: assert property (@(posedge clk) disable iff (!rst_n)
        job_valid |-> ##3 quotient_valid);

endmodule

//--- source/feature_formatter.sv
// scales window totals into features, launches both ratio jobs and registers the outputs
`timescale 1ns/1ps
`include "wfe_defines.svh"

module feature_formatter (
    input  logic                                clk,
    input  logic                                rst_n,
    window_stats_if.receiver                    stats,
    input  wfe_pkg::feature_t                   crest_quotient,
    input  wfe_pkg::feature_t                   form_quotient,
    input  logic                                quotient_valid,
    output logic [`WFE_FEAT_W+`WFE_FRAC_W-1:0]  crest_dividend,
    output wfe_pkg::feature_t                   crest_divisor,
    output logic [`WFE_FEAT_W+`WFE_FRAC_W-1:0]  form_dividend,
    output wfe_pkg::feature_t                   form_divisor,
    output logic                                job_valid,
    output wfe_pkg::feature_t                   zcr,
    output wfe_pkg::feature_t                   peak_to_peak,
    output logic signed [`WFE_FEAT_W-1:0]       mean_value,
    output wfe_pkg::feature_t                   mean_square,
    output wfe_pkg::feature_t                   crest_factor,
    output wfe_pkg::feature_t                   form_factor,
    output logic                                features_valid
);

    localparam int FW = `WFE_FEAT_W;

    logic [FW:0]        zcr_wide;
    wfe_pkg::feature_t  zcr_sat;
    wfe_pkg::feature_t  p2p;
    wfe_pkg::acc_t      mean_full;
    wfe_pkg::acc_t      msq_full;
    wfe_pkg::acc_t      mabs_full;
    wfe_pkg::feature_t  msq_sat;
    logic [4*FW-1:0]    direct_dly [4];  // prepared word, then three delay taps

    // ======================================================================
    // prepare
    // ======================================================================
    assign zcr_wide  = (FW + 1)'(stats.cross_count) << (FW - `WFE_WINDOW_LOG2);
    assign zcr_sat   = zcr_wide[FW] ? {FW{1'b1}} : zcr_wide[FW-1:0];
    assign p2p       = wfe_pkg::feature_t'(stats.peak_max) - wfe_pkg::feature_t'(stats.peak_min);
    assign mean_full = stats.sum_signal >>> `WFE_WINDOW_LOG2;
    assign msq_full  = stats.sum_square >> `WFE_WINDOW_LOG2;
    assign mabs_full = stats.sum_abs >> `WFE_WINDOW_LOG2;
    assign msq_sat   = (|msq_full[`WFE_ACC_W-1:FW]) ? {FW{1'b1}} : msq_full[FW-1:0];

    always_ff @(posedge clk) begin
        if (stats.stats_valid) begin
            crest_dividend <= {p2p, {`WFE_FRAC_W{1'b0}}};  // p2p * 256
            crest_divisor  <= msq_sat;
            form_dividend  <= {msq_sat, {`WFE_FRAC_W{1'b0}}};
            form_divisor   <= mabs_full[FW-1:0];
        end
        // direct features wait out the divider latency
        direct_dly[0] <= {zcr_sat, p2p, mean_full[FW-1:0], msq_sat};
        for (int i = 1; i < 4; i++)
            direct_dly[i] <= direct_dly[i-1];
    end

    // ======================================================================
    // output registers
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            job_valid      <= 1'b0;
            features_valid <= 1'b0;
            zcr            <= '0;
            peak_to_peak   <= '0;
            mean_value     <= '0;
            mean_square    <= '0;
            crest_factor   <= '0;
            form_factor    <= '0;
        end else begin
            job_valid      <= stats.stats_valid;
            features_valid <= quotient_valid;
            if (quotient_valid) begin  // hold until the next window
                {zcr, peak_to_peak, mean_value, mean_square} <= direct_dly[3];
                crest_factor <= crest_quotient;
                form_factor  <= form_quotient;
            end
        end
    end

    a_features_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |=> !features_valid);

endmodule

//--- source/waveform_features.sv
// top level of the waveform feature extractor: accumulator, formatter and two ratio dividers
`timescale 1ns/1ps
`include "wfe_defines.svh"

module waveform_features (
    input  logic                          clk,
    input  logic                          rst_n,
    input  wfe_pkg::sample_t              signal_in,
    input  logic                          signal_valid,
    output wfe_pkg::feature_t             zcr,
    output wfe_pkg::feature_t             peak_to_peak,
    output logic signed [`WFE_FEAT_W-1:0] mean_value,
    output wfe_pkg::feature_t             mean_square,
    output wfe_pkg::feature_t             crest_factor,
    output wfe_pkg::feature_t             form_factor,
    output logic                          features_valid
);

    logic [`WFE_FEAT_W+`WFE_FRAC_W-1:0] crest_dividend;
    logic [`WFE_FEAT_W+`WFE_FRAC_W-1:0] form_dividend;
    wfe_pkg::feature_t                  crest_divisor;
    wfe_pkg::feature_t                  form_divisor;
    wfe_pkg::feature_t                  crest_quotient;
    wfe_pkg::feature_t                  form_quotient;
    logic                               job_valid;
    logic                               quotient_valid;

    window_stats_if u_stats_if ();

    window_accumulator u_accumulator (
        .clk (clk), .rst_n (rst_n),
        .signal_in (signal_in), .signal_valid (signal_valid),
        .stats (u_stats_if.driver)
    );

    feature_formatter u_formatter (
        .clk (clk), .rst_n (rst_n),
        .stats (u_stats_if.receiver),
        .crest_quotient (crest_quotient), .form_quotient (form_quotient),
        .quotient_valid (quotient_valid),
        .crest_dividend (crest_dividend), .crest_divisor (crest_divisor),
        .form_dividend (form_dividend), .form_divisor (form_divisor),
        .job_valid (job_valid),
        .zcr (zcr), .peak_to_peak (peak_to_peak), .mean_value (mean_value),
        .mean_square (mean_square), .crest_factor (crest_factor),
        .form_factor (form_factor), .features_valid (features_valid)
    );

    ratio_divider #(.RATIO_KIND (wfe_pkg::RATIO_CREST)) u_crest_div (
        .clk (clk), .rst_n (rst_n), .job_valid (job_valid),
        .dividend (crest_dividend), .divisor (crest_divisor),
        .quotient (crest_quotient), .quotient_valid (quotient_valid)
    );

    // same latency as the crest divider, its valid is not needed
    ratio_divider #(.RATIO_KIND (wfe_pkg::RATIO_FORM)) u_form_div (
        .clk (clk), .rst_n (rst_n), .job_valid (job_valid),
        .dividend (form_dividend), .divisor (form_divisor),
        .quotient (form_quotient), .quotient_valid ()
    );

endmodule

//--- test/tb_waveform_features.sv
// drives LFSR-shaped windows into waveform_features and checks every result with assertions
`timescale 1ns/1ps
`include "wfe_defines.svh"

module tb_waveform_features;

    localparam int N           = 1 << `WFE_WINDOW_LOG2;
    localparam int NUM_WIN     = 16;
    localparam int CYCLE_LIMIT = NUM_WIN * (N + 6) * 2 + 100;

    logic                          clk;
    logic                          rst_n;
    wfe_pkg::sample_t              signal_in;
    logic                          signal_valid;
    wfe_pkg::feature_t             zcr;
    wfe_pkg::feature_t             peak_to_peak;
    logic signed [`WFE_FEAT_W-1:0] mean_value;
    wfe_pkg::feature_t             mean_square;
    wfe_pkg::feature_t             crest_factor;
    wfe_pkg::feature_t             form_factor;
    logic                          features_valid;

    logic [31:0]                   lfsr_state;
    logic                          last_accept;  // high while the window's last sample is offered
    int                            error_count;
    int                            chk_idx;      // next window to compare
    int                            cycle_count;

    // expected features per window
    logic [15:0]                   exp_zcr [NUM_WIN];
    logic [15:0]                   exp_p2p [NUM_WIN];
    logic signed [15:0]            exp_mean [NUM_WIN];
    logic [15:0]                   exp_msq [NUM_WIN];
    int                            exp_crest [NUM_WIN];  // exact quotients
    int                            exp_form [NUM_WIN];

    logic [15:0]                   cur_zcr;
    logic [15:0]                   cur_p2p;
    logic signed [15:0]            cur_mean;
    logic [15:0]                   cur_msq;
    int                            cur_crest;
    int                            cur_form;

    waveform_features i_dut (
        .clk (clk), .rst_n (rst_n),
        .signal_in (signal_in), .signal_valid (signal_valid),
        .zcr (zcr), .peak_to_peak (peak_to_peak), .mean_value (mean_value),
        .mean_square (mean_square), .crest_factor (crest_factor),
        .form_factor (form_factor), .features_valid (features_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ======================================================================
    // random source and stimulus
    // ======================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
        end
        return bits;
    endfunction

    // kind 0 full range, 1 small, 2 alternating sign, 3 all negative, 4 all zero,
    // 5 one large negative sample then zeros
    function automatic int make_sample(input int kind, input int n);
        int r;
        case (kind)
            0: begin
                r = int'(take_bits(11));
                return (r >= 1024) ? r - 2048 : r;
            end
            1: begin
                r = int'(take_bits(7));
                return (r >= 64) ? r - 128 : r;
            end
            2: begin
                r = int'(take_bits(8)) + 1;
                return n[0] ? -r : r;
            end
            3: return -int'(take_bits(10)) - 1;
            5: return (n == 0) ? -int'(take_bits(9)) - 512 : 0;  // drives form factor into saturation
            default: return 0;
        endcase
    endfunction

    function automatic int clip16(input int v);
        return (v > 65535) ? 65535 : v;
    endfunction

    task automatic drive_window(input int win, input int kind, input bit gaps);
        int n;
        int s;
        int prev;
        int sum;
        int sum_abs;
        int sum_sq;
        int smax;
        int smin;
        int crosses;
        int msq;
        int mabs;
        n = 0;
        while (n < N) begin
            @(negedge clk);
            if (gaps && take_bits(2) == 0) begin
                signal_valid = 1'b0;
                signal_in    = wfe_pkg::sample_t'(take_bits(11));  // ignored by the dut
                last_accept  = 1'b0;
            end else begin
                s            = make_sample(kind, n);
                signal_valid = 1'b1;
                signal_in    = wfe_pkg::sample_t'(s);
                last_accept  = (n == N - 1);
                if (n == 0) begin
                    sum     = s;
                    sum_abs = (s < 0) ? -s : s;
                    sum_sq  = s * s;
                    smax    = s;
                    smin    = s;
                    crosses = 0;
                end else begin
                    sum     += s;
                    sum_abs += (s < 0) ? -s : s;
                    sum_sq  += s * s;
                    if (s > smax) smax = s;
                    if (s < smin) smin = s;
                    if ((s < 0) != (prev < 0)) crosses++;
                end
                prev = s;
                n++;
            end
        end
        msq  = clip16(sum_sq >> `WFE_WINDOW_LOG2);
        mabs = sum_abs >> `WFE_WINDOW_LOG2;
        exp_zcr[win]   = 16'(clip16(crosses << (16 - `WFE_WINDOW_LOG2)));
        exp_p2p[win]   = 16'(smax - smin);
        exp_mean[win]  = 16'(sum >>> `WFE_WINDOW_LOG2);
        exp_msq[win]   = 16'(msq);
        exp_crest[win] = (msq == 0) ? 65535 : clip16(((smax - smin) * 256) / msq);
        exp_form[win]  = (mabs == 0) ? 256 : clip16((msq * 256) / mabs);
    endtask

    // ======================================================================
    // checking
    // ======================================================================
    function automatic bit within_tol(input int got, input int expected);
        int diff;
        diff = (got > expected) ? got - expected : expected - got;
        return (diff * 100) <= (expected + 100);  // 1% plus one lsb
    endfunction

    task automatic report_mismatch(input string name, input int got, input int expected);
        error_count++;
        $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, expected);
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("error at t=%0t: %s", $time, what);
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            chk_idx <= 0;
        else if (features_valid)
            chk_idx <= chk_idx + 1;
    end

    assign cur_zcr   = exp_zcr[chk_idx];
    assign cur_p2p   = exp_p2p[chk_idx];
    assign cur_mean  = exp_mean[chk_idx];
    assign cur_msq   = exp_msq[chk_idx];
    assign cur_crest = exp_crest[chk_idx];
    assign cur_form  = exp_form[chk_idx];

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (chk_idx == 0 && !features_valid) |-> (zcr == 0 && peak_to_peak == 0 &&
        mean_value == 0 && mean_square == 0 && crest_factor == 0 && form_factor == 0))
        else report_problem("outputs were not zero before the first window completed");
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        last_accept |-> ##6 features_valid)
        else report_problem("features_valid did not follow a window's last sample by 6 cycles");
    a_no_stray: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> $past(last_accept, 6))
        else report_problem("features_valid rose without a window ending 6 cycles earlier");
    a_count: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> (chk_idx < NUM_WIN))
        else report_problem("more results arrived than windows were sent");

    a_zcr: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> (zcr == cur_zcr))
        else report_mismatch("zcr", $sampled(zcr), $sampled(cur_zcr));
    a_p2p: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> (peak_to_peak == cur_p2p))
        else report_mismatch("peak_to_peak", $sampled(peak_to_peak), $sampled(cur_p2p));
    a_mean: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> (mean_value == cur_mean))
        else report_mismatch("mean_value", $sampled(mean_value), $sampled(cur_mean));
    a_msq: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> (mean_square == cur_msq))
        else report_mismatch("mean_square", $sampled(mean_square), $sampled(cur_msq));
    a_crest: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> within_tol(int'(crest_factor), cur_crest))
        else report_mismatch("crest_factor", $sampled(crest_factor), $sampled(cur_crest));
    a_form: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> within_tol(int'(form_factor), cur_form))
        else report_mismatch("form_factor", $sampled(form_factor), $sampled(cur_form));

    // ======================================================================
    // run control
    // ======================================================================
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: results still missing after %0d cycles", CYCLE_LIMIT);
        $display("windows checked: %0d of %0d, errors: %0d", chk_idx, NUM_WIN, error_count);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        error_count  = 0;
        lfsr_state   = 32'h6397_b2fa;
        signal_in    = '0;
        signal_valid = 1'b0;
        last_accept  = 1'b0;
        rst_n        = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        for (int w = 0; w < NUM_WIN; w++)
            drive_window(w, w % 6, w >= 10);  // later windows get valid gaps
        @(negedge clk);
        signal_valid = 1'b0;
        last_accept  = 1'b0;
        wait (chk_idx == NUM_WIN);
        repeat (4) @(negedge clk);
        $display("windows checked: %0d of %0d, errors: %0d", chk_idx, NUM_WIN, error_count);
        if (error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- waveform_features.f
+incdir+source
source/wfe_pkg.sv
source/window_stats_if.sv
source/window_accumulator.sv
source/reciprocal_lookup.sv
source/ratio_divider.sv
source/feature_formatter.sv
source/waveform_features.sv
test/tb_waveform_features.sv

//--- run_sim.sh
#!/bin/sh
# builds the waveform feature testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_waveform_features \
    -f waveform_features.f

./obj_dir/Vtb_waveform_features | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
